/* rtl/trace_pkg.sv */
// Trace event definitions
// Shared by the per-hart samplers, the merge buffer and the packetizer.
// Holds the event record layout, event kinds and the trace widths.

package trace_pkg;

   // cluster size and hart index width
   localparam int NUM_HARTS = 2;
   localparam int HART_W    = 1;

   localparam int ADDR_W = 32;
   localparam int TS_W   = 32;
   // lost-event counter saturates at all ones
   localparam int LOST_W = 16;

   // machine mode is assumed out of reset
   localparam logic [1:0] PRV_RESET = 2'd3;

   // merge buffer geometry
   localparam int FIFO_DEPTH = 4;
   localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);
   localparam int FIFO_CNT_W = FIFO_PTR_W + 1;

   typedef enum logic {
      EV_SAMPLE   = 1'b0,
      EV_OVERFLOW = 1'b1
   } ev_kind_t;

   // one recorded event, 101 bits
   typedef struct packed {
      logic              prv_change;
      logic              jal;
      logic              jalr;
      logic [1:0]        prv;
      logic [ADDR_W-1:0] pc;
      logic [ADDR_W-1:0] npc;
      logic [TS_W-1:0]   timestamp;
   } trace_rec_t;

endpackage

/* rtl/debug_link_pkg.sv */
// Debug link definitions
// Flit width, packet type codes, flit counts per packet and the host
// destination used by the trace packetizer.

package debug_link_pkg;

   localparam int FLIT_W = 16;

   // destination address of the host side
   localparam logic [FLIT_W-1:0] DEST_HOST = 16'h0000;

   // type code carried in the top bits of the flags flit
   localparam logic [1:0] PKT_TRACE    = 2'b01;
   localparam logic [1:0] PKT_OVERFLOW = 2'b10;

   // packet lengths in flits
   localparam int SAMPLE_FLITS   = 9;
   localparam int OVERFLOW_FLITS = 4;
   localparam int FLIT_CNT_W     = 4;

endpackage

/* rtl/trace_event_if.sv */
// Trace event channel
// Carries one event from a hart sampler to the merge arbiter with a
// valid/ready handshake. Payload holds still while valid waits for ready.

interface trace_event_if;
   import trace_pkg::*;

   logic              valid;
   logic              ready;
   ev_kind_t          kind;
   trace_rec_t        rec;
   // dropped event count, meaningful for overflow entries
   logic [LOST_W-1:0] lost;

   modport source (
      output valid, kind, rec, lost,
      input  ready
   );

   modport sink (
      input  valid, kind, rec, lost,
      output ready
   );

endinterface

/* rtl/ctm_sampler.sv */
// Per-hart trace sampler
// Records jumps and privilege changes with a cycle timestamp into a
// single-entry slot. Events arriving while the slot is full are counted
// and reported later as one overflow entry ahead of new samples.

module ctm_sampler (
   input  logic                        clk,
   input  logic                        arst_n,
   input  logic                        trace_valid,
   input  logic                        trace_jal,
   input  logic                        trace_jalr,
   input  logic                        trace_mem,
   input  logic [1:0]                  trace_prv,
   input  logic [trace_pkg::ADDR_W-1:0] trace_pc,
   input  logic [trace_pkg::ADDR_W-1:0] trace_npc,
   trace_event_if.source               ev
);
   import trace_pkg::*;

   logic [1:0]        prv_q;
   logic [TS_W-1:0]   ts_q;
   logic [LOST_W-1:0] lost_cnt_q;
   logic              slot_valid_q;
   ev_kind_t          slot_kind_q;
   trace_rec_t        slot_rec_q;
   logic [LOST_W-1:0] slot_lost_q;

   logic       prv_change;
   logic       qualify;
   logic       slot_free;
   logic       load_ovf;
   logic       load_smp;
   trace_rec_t cur_rec;

   assign prv_change = (prv_q != trace_prv);
   assign qualify    = (trace_valid & ~trace_mem & (trace_jal | trace_jalr)) | prv_change;

   assign cur_rec = '{prv_change: prv_change, jal: trace_jal, jalr: trace_jalr,
                      prv: trace_prv, pc: trace_pc, npc: trace_npc, timestamp: ts_q};

   // slot can take a new entry when empty or draining this cycle
   assign slot_free = ~slot_valid_q | ev.ready;
   // pending losses are reported before any new sample
   assign load_ovf  = slot_free & (lost_cnt_q != '0);
   assign load_smp  = slot_free & (lost_cnt_q == '0) & qualify;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         prv_q        <= PRV_RESET;
         ts_q         <= '0;
         lost_cnt_q   <= '0;
         slot_valid_q <= 1'b0;
      end else begin
         prv_q        <= trace_prv;
         ts_q         <= ts_q + 1'b1;
         if (slot_free) begin
            slot_valid_q <= load_ovf | load_smp;
         end
         if (load_ovf) begin
            // the event at this edge is dropped behind the overflow entry
            lost_cnt_q <= LOST_W'(qualify);
         end else if (!slot_free && qualify && lost_cnt_q != '1) begin
            lost_cnt_q <= lost_cnt_q + 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (load_ovf || load_smp) begin
         slot_kind_q <= load_ovf ? EV_OVERFLOW : EV_SAMPLE;
         slot_rec_q  <= cur_rec;
         slot_lost_q <= lost_cnt_q;
      end
   end

   assign ev.valid = slot_valid_q;
   assign ev.kind  = slot_kind_q;
   assign ev.rec   = slot_rec_q;
   assign ev.lost  = slot_lost_q;

   // payload is held until the merger takes it
   assert property (@(posedge clk) disable iff (!arst_n)
      ev.valid && !ev.ready |=> ev.valid && $stable(ev.rec) && $stable(ev.kind));

   // pending count never shrinks or wraps until it is reported
   assert property (@(posedge clk) disable iff (!arst_n)
      (lost_cnt_q != '0) && !load_ovf |=> lost_cnt_q >= $past(lost_cnt_q));

endmodule

/* rtl/ctm_merge.sv */
// Trace event merger
// Round-robin arbiter over all hart samplers. The granted event is
// written, tagged with its hart index, into a small circular buffer
// that drains toward the packetizer.

module ctm_merge (
   input  logic                        clk,
   input  logic                        arst_n,
   trace_event_if.sink                 ev [trace_pkg::NUM_HARTS],
   output logic                        ev_valid,
   input  logic                        ev_ready,
   output trace_pkg::ev_kind_t         ev_kind,
   output logic [trace_pkg::HART_W-1:0] ev_hart,
   output trace_pkg::trace_rec_t       ev_rec,
   output logic [trace_pkg::LOST_W-1:0] ev_lost
);
   import trace_pkg::*;

   logic [NUM_HARTS-1:0] req;
   logic [NUM_HARTS-1:0] grant;
   logic [HART_W-1:0]    gnt_idx;
   logic [HART_W-1:0]    last_q;
   ev_kind_t             kind_v [NUM_HARTS];
   trace_rec_t           rec_v  [NUM_HARTS];
   logic [LOST_W-1:0]    lost_v [NUM_HARTS];

   ev_kind_t          kind_mem [FIFO_DEPTH];
   logic [HART_W-1:0] hart_mem [FIFO_DEPTH];
   trace_rec_t        rec_mem  [FIFO_DEPTH];
   logic [LOST_W-1:0] lost_mem [FIFO_DEPTH];
   logic [FIFO_PTR_W-1:0] wr_ptr_q;
   logic [FIFO_PTR_W-1:0] rd_ptr_q;
   logic [FIFO_CNT_W-1:0] count_q;
   logic full;
   logic wr_en;
   logic rd_en;

   for (genvar i = 0; i < NUM_HARTS; i++) begin : g_port
      assign req[i]      = ev[i].valid;
      assign kind_v[i]   = ev[i].kind;
      assign rec_v[i]    = ev[i].rec;
      assign lost_v[i]   = ev[i].lost;
      assign ev[i].ready = grant[i];
   end

   assign full = (count_q == FIFO_CNT_W'(FIFO_DEPTH));

   // search starts at the hart after the last grant
   always_comb begin
      int idx;
      grant   = '0;
      gnt_idx = last_q;
      for (int k = 1; k <= NUM_HARTS; k++) begin
         idx = (int'(last_q) + k) % NUM_HARTS;
         if (!full && grant == '0 && req[idx]) begin
            grant[idx] = 1'b1;
            gnt_idx    = HART_W'(idx);
         end
      end
   end

   assign wr_en = |grant;
   assign rd_en = ev_valid & ev_ready;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         last_q   <= HART_W'(NUM_HARTS - 1);
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
      end else begin
         if (wr_en) begin
            last_q   <= gnt_idx;
            wr_ptr_q <= wr_ptr_q + 1'b1;
         end
         if (rd_en) begin
            rd_ptr_q <= rd_ptr_q + 1'b1;
         end
         case ({wr_en, rd_en})
            2'b10:   count_q <= count_q + 1'b1;
            2'b01:   count_q <= count_q - 1'b1;
            default: count_q <= count_q;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (wr_en) begin
         kind_mem[wr_ptr_q] <= kind_v[gnt_idx];
         hart_mem[wr_ptr_q] <= gnt_idx;
         rec_mem[wr_ptr_q]  <= rec_v[gnt_idx];
         lost_mem[wr_ptr_q] <= lost_v[gnt_idx];
      end
   end

   assign ev_valid = (count_q != '0);
   assign ev_kind  = kind_mem[rd_ptr_q];
   assign ev_hart  = hart_mem[rd_ptr_q];
   assign ev_rec   = rec_mem[rd_ptr_q];
   assign ev_lost  = lost_mem[rd_ptr_q];

   // a write into a full buffer would push the count past the depth
   assert property (@(posedge clk) disable iff (!arst_n)
      count_q <= FIFO_CNT_W'(FIFO_DEPTH));
   assert property (@(posedge clk) disable iff (!arst_n) $onehot0(grant));

endmodule

/* rtl/ctm_packetizer.sv */
// Trace packetizer
// Latches one buffered event and sends it as a sequence of debug flits.
// Sample packets carry timestamp, pc and npc; overflow packets carry
// the number of dropped events.

module ctm_packetizer (
   input  logic                             clk,
   input  logic                             arst_n,
   input  logic [9:0]                       id,
   input  logic                             ev_valid,
   output logic                             ev_ready,
   input  trace_pkg::ev_kind_t              ev_kind,
   input  logic [trace_pkg::HART_W-1:0]     ev_hart,
   input  trace_pkg::trace_rec_t            ev_rec,
   input  logic [trace_pkg::LOST_W-1:0]     ev_lost,
   output logic [debug_link_pkg::FLIT_W-1:0] debug_out_data,
   output logic                             debug_out_last,
   output logic                             debug_out_valid,
   input  logic                             debug_out_ready
);
   import trace_pkg::*;
   import debug_link_pkg::*;

   logic                  busy_q;
   logic [FLIT_CNT_W-1:0] cnt_q;
   ev_kind_t              kind_q;
   logic [HART_W-1:0]     hart_q;
   trace_rec_t            rec_q;
   logic [LOST_W-1:0]     lost_q;
   logic [FLIT_W-1:0]     flags;
   logic                  is_ovf;

   assign ev_ready = ~busy_q;
   assign is_ovf   = (kind_q == EV_OVERFLOW);

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         busy_q <= 1'b0;
         cnt_q  <= '0;
      end else if (!busy_q) begin
         busy_q <= ev_valid;
         cnt_q  <= '0;
      end else if (debug_out_ready) begin
         busy_q <= ~debug_out_last;
         cnt_q  <= cnt_q + 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (ev_valid && ev_ready) begin
         kind_q <= ev_kind;
         hart_q <= ev_hart;
         rec_q  <= ev_rec;
         lost_q <= ev_lost;
      end
   end

   // type in 15:14, hart at 8, event bits in 4:0
   always_comb begin
      flags                = '0;
      flags[15:14]         = is_ovf ? PKT_OVERFLOW : PKT_TRACE;
      flags[8 +: HART_W]   = hart_q;
      if (!is_ovf) begin
         flags[4:0] = {rec_q.prv_change, rec_q.jal, rec_q.jalr, rec_q.prv};
      end
   end

   always_comb begin
      case (cnt_q)
         4'd0:    debug_out_data = DEST_HOST;
         4'd1:    debug_out_data = FLIT_W'(id);
         4'd2:    debug_out_data = flags;
         4'd3:    debug_out_data = is_ovf ? lost_q : rec_q.timestamp[15:0];
         4'd4:    debug_out_data = rec_q.timestamp[31:16];
         4'd5:    debug_out_data = rec_q.pc[15:0];
         4'd6:    debug_out_data = rec_q.pc[31:16];
         4'd7:    debug_out_data = rec_q.npc[15:0];
         4'd8:    debug_out_data = rec_q.npc[31:16];
         default: debug_out_data = '0;
      endcase
   end

   assign debug_out_valid = busy_q;
   assign debug_out_last  = is_ovf ? (cnt_q == FLIT_CNT_W'(OVERFLOW_FLITS - 1))
                                   : (cnt_q == FLIT_CNT_W'(SAMPLE_FLITS - 1));

   // flit held while the link stalls
   assert property (@(posedge clk) disable iff (!arst_n)
      debug_out_valid && !debug_out_ready |=>
         debug_out_valid && $stable(debug_out_data) && $stable(debug_out_last));

endmodule

/* rtl/ctm_top.sv */
// Core trace monitor top
// One sampler per hart watches the retired instruction trace, a
// round-robin merger buffers their events and the packetizer sends
// them out as debug flits.

module ctm_top (
   input  logic                                 clk,
   input  logic                                 arst_n,
   input  logic [9:0]                           id,
   input  logic [trace_pkg::NUM_HARTS-1:0]      trace_valid,
   input  logic [trace_pkg::NUM_HARTS-1:0]      trace_jal,
   input  logic [trace_pkg::NUM_HARTS-1:0]      trace_jalr,
   input  logic [trace_pkg::NUM_HARTS-1:0]      trace_mem,
   input  logic [1:0]                           trace_prv [trace_pkg::NUM_HARTS],
   input  logic [trace_pkg::ADDR_W-1:0]         trace_pc  [trace_pkg::NUM_HARTS],
   input  logic [trace_pkg::ADDR_W-1:0]         trace_npc [trace_pkg::NUM_HARTS],
   output logic [debug_link_pkg::FLIT_W-1:0]    debug_out_data,
   output logic                                 debug_out_last,
   output logic                                 debug_out_valid,
   input  logic                                 debug_out_ready
);
   import trace_pkg::*;

   logic              ev_valid;
   logic              ev_ready;
   ev_kind_t          ev_kind;
   logic [HART_W-1:0] ev_hart;
   trace_rec_t        ev_rec;
   logic [LOST_W-1:0] ev_lost;

   trace_event_if ev_if [NUM_HARTS] ();

   for (genvar h = 0; h < NUM_HARTS; h++) begin : g_hart
      ctm_sampler u_sampler (
         .clk         (clk),
         .arst_n      (arst_n),
         .trace_valid (trace_valid[h]),
         .trace_jal   (trace_jal[h]),
         .trace_jalr  (trace_jalr[h]),
         .trace_mem   (trace_mem[h]),
         .trace_prv   (trace_prv[h]),
         .trace_pc    (trace_pc[h]),
         .trace_npc   (trace_npc[h]),
         .ev          (ev_if[h])
      );
   end

   ctm_merge u_merge (
      .clk      (clk),
      .arst_n   (arst_n),
      .ev       (ev_if),
      .ev_valid (ev_valid),
      .ev_ready (ev_ready),
      .ev_kind  (ev_kind),
      .ev_hart  (ev_hart),
      .ev_rec   (ev_rec),
      .ev_lost  (ev_lost)
   );

   ctm_packetizer u_packetizer (
      .clk             (clk),
      .arst_n          (arst_n),
      .id              (id),
      .ev_valid        (ev_valid),
      .ev_ready        (ev_ready),
      .ev_kind         (ev_kind),
      .ev_hart         (ev_hart),
      .ev_rec          (ev_rec),
      .ev_lost         (ev_lost),
      .debug_out_data  (debug_out_data),
      .debug_out_last  (debug_out_last),
      .debug_out_valid (debug_out_valid),
      .debug_out_ready (debug_out_ready)
   );

endmodule

/* sim/ctm_tb.sv */
// Core trace monitor testbench
// Reads per-cycle trace stimulus and expected flit packets from a data
// file, drives the DUT and checks every accepted flit. All packets are
// also decoded so that per-hart event counts can be checked after the
// overflow burst.

module ctm_tb;
   timeunit 1ns;
   timeprecision 1ps;

   import trace_pkg::*;
   import debug_link_pkg::*;

   localparam logic [31:0] SEED = 32'h31a5_192c;

   // one stimulus line, repeated rep cycles
   typedef struct packed {
      logic [15:0]                      rep;
      logic [1:0]                       rdy;
      logic [NUM_HARTS-1:0]             v;
      logic [NUM_HARTS-1:0]             jal;
      logic [NUM_HARTS-1:0]             jalr;
      logic [NUM_HARTS-1:0]             mem;
      logic [NUM_HARTS-1:0][1:0]        prv;
      logic [NUM_HARTS-1:0][ADDR_W-1:0] pc;
      logic [NUM_HARTS-1:0][ADDR_W-1:0] npc;
   } stim_t;

   logic                 clk = 1'b0;
   logic                 arst_n;
   logic [9:0]           id;
   logic [NUM_HARTS-1:0] trace_valid;
   logic [NUM_HARTS-1:0] trace_jal;
   logic [NUM_HARTS-1:0] trace_jalr;
   logic [NUM_HARTS-1:0] trace_mem;
   logic [1:0]           trace_prv [NUM_HARTS];
   logic [ADDR_W-1:0]    trace_pc  [NUM_HARTS];
   logic [ADDR_W-1:0]    trace_npc [NUM_HARTS];
   logic [FLIT_W-1:0]    debug_out_data;
   logic                 debug_out_last;
   logic                 debug_out_valid;
   logic                 debug_out_ready;

   stim_t       stim_q [$];
   // {last, flit}
   logic [16:0] exp_q [$];
   logic [9:0]  id_val = '0;
   int          stim_cycles = 0;
   int          limit = 0;
   int          cycle = 0;
   int          errors = 0;
   int          checks = 0;
   int          ovf_seen = 0;
   int          qual  [NUM_HARTS] = '{default: 0};
   int          tally [NUM_HARTS] = '{default: 0};
   logic [1:0]  prv_prev [NUM_HARTS] = '{default: PRV_RESET};
   logic        stim_done = 1'b0;

   // output monitor state
   logic [FLIT_W-1:0] pkt [16];
   int                pos = 0;
   logic              stall_q = 1'b0;
   logic [FLIT_W-1:0] held_data;
   logic              held_last;
   logic [TS_W-1:0]   last_ts [NUM_HARTS];
   logic              ts_seen [NUM_HARTS] = '{default: 1'b0};

   always #50 clk = ~clk;

   ctm_top u_dut (
      .clk             (clk),
      .arst_n          (arst_n),
      .id              (id),
      .trace_valid     (trace_valid),
      .trace_jal       (trace_jal),
      .trace_jalr      (trace_jalr),
      .trace_mem       (trace_mem),
      .trace_prv       (trace_prv),
      .trace_pc        (trace_pc),
      .trace_npc       (trace_npc),
      .debug_out_data  (debug_out_data),
      .debug_out_last  (debug_out_last),
      .debug_out_valid (debug_out_valid),
      .debug_out_ready (debug_out_ready)
   );

   task automatic check(input string name, input logic [31:0] exp_val,
                        input logic [31:0] got_val);
      checks++;
      if (exp_val !== got_val) begin
         errors++;
         $display("[FAIL] %s expected=0x%0h got=0x%0h", name, exp_val, got_val);
      end
   endtask

   task automatic read_stimulus();
      int          fd;
      int          n;
      string       line;
      logic [31:0] f [16];
      stim_t       s;
      fd = $fopen("sim/trace_input.txt", "r");
      if (fd == 0) begin
         errors++;
         $display("could not open the stimulus file sim/trace_input.txt");
         return;
      end
      while (!$feof(fd)) begin
         line = "";
         n = $fgets(line, fd);
         if (n <= 1 || line.getc(0) == "#") begin
            continue;
         end
         case (line.getc(0))
            "S": begin
               n = $sscanf(line, "S %d %d %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                           f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7],
                           f[8], f[9], f[10], f[11], f[12], f[13], f[14], f[15]);
               if (n != 16) begin
                  errors++;
                  $display("malformed stimulus line: %s", line);
               end
               s.rep = f[0][15:0];
               s.rdy = f[1][1:0];
               for (int h = 0; h < NUM_HARTS; h++) begin
                  s.v[h]    = f[2 + 7 * h][0];
                  s.jal[h]  = f[3 + 7 * h][0];
                  s.jalr[h] = f[4 + 7 * h][0];
                  s.mem[h]  = f[5 + 7 * h][0];
                  s.prv[h]  = f[6 + 7 * h][1:0];
                  s.pc[h]   = f[7 + 7 * h];
                  s.npc[h]  = f[8 + 7 * h];
               end
               stim_q.push_back(s);
               stim_cycles += int'(s.rep);
            end
            "P": begin
               n = $sscanf(line, "P %h %h %h %h %h %h %h %h %h",
                           f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8]);
               for (int k = 0; k < n; k++) begin
                  exp_q.push_back({k == n - 1, f[k][FLIT_W-1:0]});
               end
            end
            "I": begin
               n = $sscanf(line, "I %h", f[0]);
               id_val = f[0][9:0];
            end
            default: begin
               errors++;
               $display("unknown line in the stimulus file: %s", line);
            end
         endcase
      end
      $fclose(fd);
   endtask

   // drives one cycle and counts the events that should be recorded
   task automatic drive_cycle(input stim_t s);
      logic [31:0] r;
      logic        jump;
      trace_valid <= s.v;
      trace_jal   <= s.jal;
      trace_jalr  <= s.jalr;
      trace_mem   <= s.mem;
      for (int h = 0; h < NUM_HARTS; h++) begin
         trace_prv[h] <= s.prv[h];
         trace_pc[h]  <= s.pc[h];
         trace_npc[h] <= s.npc[h];
         jump = s.v[h] & ~s.mem[h] & (s.jal[h] | s.jalr[h]);
         if (jump || s.prv[h] != prv_prev[h]) begin
            qual[h]++;
         end
         prv_prev[h] = s.prv[h];
      end
      if (s.rdy == 2'd2) begin
         r = $urandom();
         debug_out_ready <= r[0];
      end else begin
         debug_out_ready <= s.rdy[0];
      end
   endtask

   // compares one accepted flit and decodes the packet at its last flit
   task automatic take_flit();
      logic [16:0]     e;
      logic [1:0]      ptype;
      int              h;
      logic [TS_W-1:0] ts;
      if (exp_q.size() > 0) begin
         e = exp_q.pop_front();
         check("debug_out_data", 32'(e[FLIT_W-1:0]), 32'(debug_out_data));
         check("debug_out_last", 32'(e[16]), 32'(debug_out_last));
      end
      if (pos < 16) begin
         pkt[pos] = debug_out_data;
      end
      pos++;
      if (debug_out_last) begin
         check("dest flit", 32'(DEST_HOST), 32'(pkt[0]));
         check("id flit", 32'(id), 32'(pkt[1]));
         ptype = pkt[2][15:14];
         h     = int'(pkt[2][8 +: HART_W]);
         if (ptype == PKT_TRACE) begin
            check("sample packet length", 32'(SAMPLE_FLITS), 32'(pos));
            ts = {pkt[4], pkt[3]};
            if (ts_seen[h] && ts <= last_ts[h]) begin
               errors++;
               $display("hart %0d sample 0x%0h came after sample 0x%0h", h, ts, last_ts[h]);
            end
            ts_seen[h] = 1'b1;
            last_ts[h] = ts;
            tally[h]++;
         end else if (ptype == PKT_OVERFLOW) begin
            check("overflow packet length", 32'(OVERFLOW_FLITS), 32'(pos));
            if (pkt[3] == '0) begin
               errors++;
               $display("hart %0d sent an overflow packet with a zero count", h);
            end
            tally[h] += int'(pkt[3]);
            ovf_seen++;
         end else begin
            errors++;
            $display("packet with unknown type code %0d", ptype);
         end
         pos = 0;
      end
   endtask

   function automatic logic output_drained();
      logic ok;
      ok = stim_done && exp_q.size() == 0 && pos == 0 && !debug_out_valid;
      for (int h = 0; h < NUM_HARTS; h++) begin
         if (tally[h] < qual[h]) begin
            ok = 1'b0;
         end
      end
      return ok;
   endfunction

   always @(posedge clk) begin
      if (arst_n === 1'b1) begin
         cycle++;
         if (cycle > limit) begin
            $display("output stopped: %0d cycles passed with packets still missing", cycle);
            $display("Regression failed");
            $finish;
         end else begin
            // a stalled flit must still be there at the next edge
            if (stall_q) begin
               check("debug_out_valid held", 32'(1), 32'(debug_out_valid));
               check("debug_out_data held", 32'(held_data), 32'(debug_out_data));
               check("debug_out_last held", 32'(held_last), 32'(debug_out_last));
            end
            if (debug_out_valid && debug_out_ready) begin
               take_flit();
            end
            stall_q   = debug_out_valid & ~debug_out_ready;
            held_data = debug_out_data;
            held_last = debug_out_last;
         end
      end
   end

   initial begin
      arst_n          = 1'b0;
      id              = '0;
      trace_valid     = '0;
      trace_jal       = '0;
      trace_jalr      = '0;
      trace_mem       = '0;
      debug_out_ready = 1'b0;
      for (int h = 0; h < NUM_HARTS; h++) begin
         trace_prv[h] = PRV_RESET;
         trace_pc[h]  = '0;
         trace_npc[h] = '0;
      end
      void'($urandom(SEED));
      read_stimulus();
      limit = 4 * stim_cycles + exp_q.size();
      id    = id_val;

      repeat (4) @(posedge clk);
      arst_n <= 1'b1;
      foreach (stim_q[i]) begin
         for (int r = 0; r < int'(stim_q[i].rep); r++) begin
            drive_cycle(stim_q[i]);
            @(posedge clk);
         end
      end
      trace_valid     <= '0;
      debug_out_ready <= 1'b1;
      stim_done = 1'b1;

      while (!output_drained()) begin
         @(posedge clk);
      end
      for (int h = 0; h < NUM_HARTS; h++) begin
         check($sformatf("hart%0d event count", h), 32'(qual[h]), 32'(tally[h]));
      end
      check("overflow packets seen", 32'(1), 32'(ovf_seen > 0));

      $display("checks=%0d errors=%0d", checks, errors);
      if (errors == 0) begin
         $display("Regression passed");
      end else begin
         $display("Regression failed");
      end
      $finish;
   end

endmodule

/* sim/trace_input.txt */
# S count ready(0 low 1 high 2 random), per hart 0 then 1: valid jal jalr mem prv pc npc
# P flits of one expected packet in output order, I cluster id; all hex except S count, ready
I 155
# single jal on hart 0
S 3 1 0 0 0 0 3 00000000 00000000 0 0 0 0 3 00000000 00000000
S 1 1 1 1 0 0 3 80001000 80002040 0 0 0 0 3 00000000 00000000
S 20 1 0 0 0 0 3 00000000 00000000 0 0 0 0 3 00000000 00000000
# memory jump, jump without valid, plain instruction, privilege change on hart 1
S 1 1 1 1 0 1 3 00001100 00001200 1 0 1 1 3 00002100 00002200
S 1 1 0 1 0 0 3 00001104 00001300 0 0 0 0 3 00000000 00000000
S 1 1 1 0 0 0 3 00001108 0000110c 1 0 0 0 3 00002104 00002108
S 1 1 0 0 0 0 3 00000000 00000000 0 0 0 0 1 00000400 00000404
S 20 1 0 0 0 0 3 00000000 00000000 0 0 0 0 1 00000000 00000000
# jumps on both harts in the same cycle
S 1 1 1 0 1 0 3 00003000 00003104 1 0 1 0 1 00005000 0000500c
S 1 1 0 0 0 0 3 00000000 00000000 0 0 0 0 1 00000000 00000000
S 1 1 1 1 0 0 3 00003104 00003200 1 1 0 0 1 0000500c 00005100
# stalled link, then random ready, then drain
S 10 0 0 0 0 0 3 00000000 00000000 0 0 0 0 1 00000000 00000000
S 100 2 0 0 0 0 3 00000000 00000000 0 0 0 0 1 00000000 00000000
S 40 1 0 0 0 0 3 00000000 00000000 0 0 0 0 1 00000000 00000000
# burst on both harts while the link is stalled
S 12 0 1 1 0 0 3 00006000 00006100 1 0 1 0 1 00007000 00007010
S 20 0 0 0 0 0 3 00000000 00000000 0 0 0 0 1 00000000 00000000
S 120 1 0 0 0 0 3 00000000 00000000 0 0 0 0 1 00000000 00000000
# expected packets ahead of the burst
P 0000 0155 400b 0003 0000 1000 8000 2040 8000
P 0000 0155 4111 001b 0000 0400 0000 0404 0000
P 0000 0155 4007 0030 0000 3000 0000 3104 0000
P 0000 0155 4105 0030 0000 5000 0000 500c 0000
P 0000 0155 400b 0032 0000 3104 0000 3200 0000
P 0000 0155 4109 0032 0000 500c 0000 5100 0000

/* sim.f */
rtl/trace_pkg.sv
rtl/debug_link_pkg.sv
rtl/trace_event_if.sv
rtl/ctm_sampler.sv
rtl/ctm_merge.sv
rtl/ctm_packetizer.sv
rtl/ctm_top.sv
sim/ctm_tb.sv

/* run_sim.sh */
#!/bin/sh
# build the trace monitor testbench with Verilator and run it
LOG=sim.log
rm -rf obj_dir
verilator --binary --timing --assert -j 0 --top-module ctm_tb -f sim.f -o ctm_tb_sim \
   > "$LOG" 2>&1 &&
   ./obj_dir/ctm_tb_sim >> "$LOG" 2>&1 ||
   { cat "$LOG"; echo "build or simulation error"; exit 1; }
cat "$LOG"
grep -q "Regression failed" "$LOG" && exit 1 || exit 0
